/* rtl/gfx_pkg.sv */
package gfx_pkg;

    ////////////////////
    // Buffer geometry
    ////////////////////

    localparam int fb_width  = 16;
    localparam int fb_height = 8;

    // Screen row r shows buffer row fb_height-1-r
    localparam int flip_vertical = 1;

    // Cycles the command soft reset stays high
    localparam int soft_reset_hold = 16;

    ////////////////////
    // Video timing
    ////////////////////

    localparam int h_active = 16;
    localparam int h_front  = 2;
    localparam int h_sync   = 3;
    localparam int h_back   = 3;
    localparam int h_total  = h_active + h_front + h_sync + h_back;

    localparam int v_active = 8;
    localparam int v_front  = 1;
    localparam int v_sync   = 2;
    localparam int v_back   = 1;
    localparam int v_total  = v_active + v_front + v_sync + v_back;

    ////////////////////
    // Commands
    ////////////////////

    typedef enum logic [3:0] {
        op_nop        = 4'd0,
        op_pixel      = 4'd1,
        op_fill       = 4'd2,
        op_soft_reset = 4'd3
    } opcode_t;

    // Red nibble on top, then green, then blue
    typedef logic [11:0] color_t;

    // Row times 16 plus column
    typedef logic [6:0] fb_addr_t;

    typedef struct packed {
        opcode_t    opcode;
        logic [2:0] y;
        logic [3:0] x;
        logic [8:0] unused;
        color_t     color;
    } pixel_cmd_t;

    typedef struct packed {
        opcode_t    opcode;
        logic [3:0] x0;
        logic [2:0] y0;
        logic [3:0] x1;
        logic [2:0] y1;
        logic [1:0] unused;
        color_t     color;
    } fill_cmd_t;

    // First byte on the wire lands in the top bits
    typedef union packed {
        pixel_cmd_t pixel;
        fill_cmd_t  fill;
    } cmd_word_t;

endpackage

/* rtl/spi_sub.sv */
`timescale 1ns/1ps

module spi_sub (
    input  logic       clk_ext,
    input  logic       reset,
    input  logic       sclk,
    input  logic       ssn,
    input  logic       mosi,
    input  logic       busy,
    input  logic       soft_reset,
    input  logic       byte_ready,
    output logic       miso,
    output logic       byte_valid,
    output logic [7:0] byte_data
);
    // Two sync stages plus the previous level in the third bit
    logic [2:0] sclk_q;
    logic [2:0] ssn_q;
    logic [1:0] mosi_q;
    logic       sclk_rise;
    logic       sclk_fall;
    logic       ssn_fall;
    logic       byte_done;
    logic       accept_new;
    logic [2:0] bit_count;
    logic [6:0] rx_shift;
    logic [7:0] tx_shift;
    logic       overrun;

    always_ff @(posedge clk_ext or posedge reset) begin
        if (reset) begin
            sclk_q <= '0;
            ssn_q  <= '1;
            mosi_q <= '0;
        end else begin
            sclk_q <= {sclk_q[1:0], sclk};
            ssn_q  <= {ssn_q[1:0], ssn};
            mosi_q <= {mosi_q[0], mosi};
        end
    end

    assign sclk_rise  = sclk_q[1] && !sclk_q[2] && !ssn_q[1];
    assign sclk_fall  = !sclk_q[1] && sclk_q[2] && !ssn_q[1];
    assign ssn_fall   = !ssn_q[1] && ssn_q[2];
    assign byte_done  = sclk_rise && (bit_count == 3'd7);
    // Previous byte still held means the new one is lost
    assign accept_new = byte_done && (!byte_valid || byte_ready);
    assign miso       = tx_shift[7];

    always_ff @(posedge clk_ext or posedge reset) begin
        if (reset) begin
            bit_count <= '0;
            tx_shift  <= '0;
        end else if (ssn_q[1]) begin
            bit_count <= '0;
        end else begin
            if (sclk_rise) begin
                bit_count <= bit_count + 3'd1;
            end
            // Status goes out at the start of every byte
            if (ssn_fall || byte_done) begin
                tx_shift <= {6'b0, overrun, busy};
            end else if (sclk_fall && bit_count != 3'd0) begin
                tx_shift <= {tx_shift[6:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk_ext or posedge reset) begin
        if (reset) begin
            byte_valid <= 1'b0;
            overrun    <= 1'b0;
        end else begin
            if (accept_new) begin
                byte_valid <= 1'b1;
            end else if (byte_valid && byte_ready) begin
                byte_valid <= 1'b0;
            end
            if (soft_reset) begin
                overrun <= 1'b0;
            end else if (byte_done && !accept_new) begin
                overrun <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_ext) begin
        if (sclk_rise) begin
            rx_shift <= {rx_shift[5:0], mosi_q[1]};
        end
        if (accept_new) begin
            byte_data <= {rx_shift, mosi_q[1]};
        end
    end

endmodule

/* rtl/cmd_decoder.sv */
`timescale 1ns/1ps

module cmd_decoder (
    input  logic            clk_ext,
    input  logic            reset,
    input  logic            byte_valid,
    input  logic [7:0]      byte_data,
    input  logic            draw_ready,
    output logic            byte_ready,
    output logic            draw_valid,
    output logic            draw_fill,
    output logic [3:0]      draw_x0,
    output logic [2:0]      draw_y0,
    output logic [3:0]      draw_x1,
    output logic [2:0]      draw_y1,
    output gfx_pkg::color_t draw_color,
    output logic            soft_reset
);
    import gfx_pkg::*;

    cmd_word_t cmd_word;
    cmd_word_t next_word;
    opcode_t   opcode;
    logic [1:0] byte_count;
    logic       byte_fire;
    logic       cmd_done;
    logic [$clog2(soft_reset_hold)-1:0] hold_count;

    // No new bytes while a draw waits for the writer
    assign byte_ready = !draw_valid;
    assign byte_fire  = byte_valid && byte_ready;
    assign next_word  = {cmd_word[23:0], byte_data};
    assign cmd_done   = byte_fire && (byte_count == 2'd3);
    assign opcode     = next_word.pixel.opcode;

    always_ff @(posedge clk_ext or posedge reset) begin
        if (reset) begin
            byte_count <= '0;
            draw_valid <= 1'b0;
            soft_reset <= 1'b0;
            hold_count <= '0;
        end else begin
            if (byte_fire) begin
                byte_count <= byte_count + 2'd1;
            end
            if (cmd_done && (opcode == op_pixel || opcode == op_fill)) begin
                draw_valid <= 1'b1;
            end else if (draw_valid && draw_ready) begin
                draw_valid <= 1'b0;
            end
            // Soft reset held for a fixed count, then released
            if (cmd_done && opcode == op_soft_reset) begin
                soft_reset <= 1'b1;
                hold_count <= ($clog2(soft_reset_hold))'(soft_reset_hold - 1);
                byte_count <= '0;
            end else if (hold_count != '0) begin
                hold_count <= hold_count - 1'b1;
            end else begin
                soft_reset <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_ext) begin
        if (byte_fire) begin
            cmd_word <= next_word;
        end
        if (cmd_done) begin
            draw_fill <= (opcode == op_fill);
            if (opcode == op_fill) begin
                // Field widths already keep the corners inside the buffer
                draw_x0    <= next_word.fill.x0;
                draw_y0    <= next_word.fill.y0;
                draw_x1    <= next_word.fill.x1;
                draw_y1    <= next_word.fill.y1;
                draw_color <= next_word.fill.color;
            end else begin
                // Single pixel is a 1x1 rectangle
                draw_x0    <= next_word.pixel.x;
                draw_y0    <= next_word.pixel.y;
                draw_x1    <= next_word.pixel.x;
                draw_y1    <= next_word.pixel.y;
                draw_color <= next_word.pixel.color;
            end
        end
    end

endmodule

/* rtl/frame_writer.sv */
`timescale 1ns/1ps

module frame_writer (
    input  logic              clk_ext,
    input  logic              reset,
    input  logic              draw_valid,
    input  logic              draw_fill,
    input  logic [3:0]        draw_x0,
    input  logic [2:0]        draw_y0,
    input  logic [3:0]        draw_x1,
    input  logic [2:0]        draw_y1,
    input  gfx_pkg::color_t   draw_color,
    output logic              draw_ready,
    output logic              busy,
    output logic              wr_en,
    output gfx_pkg::fb_addr_t wr_addr,
    output gfx_pkg::color_t   wr_data
);
    import gfx_pkg::*;

    logic       active;
    logic       draw_fire;
    logic       empty;
    logic [3:0] end_x;
    logic [2:0] end_y;
    logic [3:0] cur_x;
    logic [2:0] cur_y;
    logic [3:0] col_start;
    logic [3:0] col_end;
    logic [2:0] row_end;
    color_t     color;

    assign draw_ready = !active;
    assign draw_fire  = draw_valid && draw_ready;
    assign end_x      = draw_fill ? draw_x1 : draw_x0;
    assign end_y      = draw_fill ? draw_y1 : draw_y0;
    assign empty      = (end_x < draw_x0) || (end_y < draw_y0);
    assign busy       = active || draw_valid;

    // One write per cycle while walking the rectangle
    assign wr_en   = active;
    assign wr_addr = fb_addr_t'(cur_y * fb_width + cur_x);
    assign wr_data = color;

    always_ff @(posedge clk_ext or posedge reset) begin
        if (reset) begin
            active <= 1'b0;
            cur_x  <= '0;
            cur_y  <= '0;
        end else if (draw_fire) begin
            active <= !empty;
            cur_x  <= draw_x0;
            cur_y  <= draw_y0;
        end else if (active) begin
            if (cur_x == col_end) begin
                cur_x <= col_start;
                if (cur_y == row_end) begin
                    active <= 1'b0;
                end else begin
                    cur_y <= cur_y + 3'd1;
                end
            end else begin
                cur_x <= cur_x + 4'd1;
            end
        end
    end

    always_ff @(posedge clk_ext) begin
        if (draw_fire) begin
            col_start <= draw_x0;
            col_end   <= end_x;
            row_end   <= end_y;
            color     <= draw_color;
        end
    end

endmodule

/* rtl/frame_buffer.sv */
`timescale 1ns/1ps

module frame_buffer (
    input  logic              clk_ext,
    input  logic              wr_en,
    input  gfx_pkg::fb_addr_t wr_addr,
    input  gfx_pkg::color_t   wr_data,
    input  gfx_pkg::fb_addr_t rd_addr,
    output gfx_pkg::color_t   rd_data
);
    import gfx_pkg::*;

    color_t mem [fb_width * fb_height];

    // Power-up contents are black
    initial begin
        for (int i = 0; i < fb_width * fb_height; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk_ext) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

/* rtl/video_timing.sv */
`timescale 1ns/1ps

module video_timing (
    input  logic                                 clk_ext,
    input  logic                                 reset,
    input  logic                                 soft_reset,
    output logic [$clog2(gfx_pkg::h_total)-1:0] h_pos,
    output logic [$clog2(gfx_pkg::v_total)-1:0] v_pos,
    output logic                                 active,
    output logic                                 hsync,
    output logic                                 vsync
);
    import gfx_pkg::*;

    always_ff @(posedge clk_ext or posedge reset) begin
        if (reset) begin
            h_pos <= '0;
            v_pos <= '0;
        end else if (soft_reset) begin
            h_pos <= '0;
            v_pos <= '0;
        end else if (h_pos == h_total - 1) begin
            h_pos <= '0;
            if (v_pos == v_total - 1) begin
                v_pos <= '0;
            end else begin
                v_pos <= v_pos + 1'b1;
            end
        end else begin
            h_pos <= h_pos + 1'b1;
        end
    end

    assign active = (h_pos < h_active) && (v_pos < v_active);

    // Syncs are active low, inside the porch window
    assign hsync = !((h_pos >= h_active + h_front) &&
                     (h_pos < h_active + h_front + h_sync));
    assign vsync = !((v_pos >= v_active + v_front) &&
                     (v_pos < v_active + v_front + v_sync));

endmodule

/* rtl/scanout.sv */
`timescale 1ns/1ps

module scanout (
    input  logic                                 clk_ext,
    input  logic                                 reset,
    input  logic [$clog2(gfx_pkg::h_total)-1:0] h_pos,
    input  logic [$clog2(gfx_pkg::v_total)-1:0] v_pos,
    input  logic                                 active,
    input  logic                                 hsync,
    input  logic                                 vsync,
    input  gfx_pkg::color_t                      rd_data,
    output gfx_pkg::fb_addr_t                    rd_addr,
    output logic                                 vga_hsync,
    output logic                                 vga_vsync,
    output logic [3:0]                           vga_red,
    output logic [3:0]                           vga_green,
    output logic [3:0]                           vga_blue,
    output logic [4:0]                           screen_red,
    output logic [5:0]                           screen_green,
    output logic [4:0]                           screen_blue,
    output logic                                 screen_data_enable
);
    import gfx_pkg::*;

    logic [$clog2(fb_width)-1:0]  col;
    logic [$clog2(fb_height)-1:0] row;
    logic [1:0] active_d;
    logic [1:0] hsync_d;
    logic [1:0] vsync_d;
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;

    assign col = h_pos[$clog2(fb_width)-1:0];
    // Panel is mounted upside down
    assign row = (flip_vertical != 0) ? ($clog2(fb_height))'(fb_height - 1 - int'(v_pos))
                                      : v_pos[$clog2(fb_height)-1:0];

    always_ff @(posedge clk_ext) begin
        rd_addr <= fb_addr_t'(row * fb_width + col);
    end

    // Address register plus RAM read
    always_ff @(posedge clk_ext or posedge reset) begin
        if (reset) begin
            active_d <= '0;
            hsync_d  <= '1;
            vsync_d  <= '1;
        end else begin
            active_d <= {active_d[0], active};
            hsync_d  <= {hsync_d[0], hsync};
            vsync_d  <= {vsync_d[0], vsync};
        end
    end

    // Black outside the visible area
    assign red   = active_d[1] ? rd_data[11:8] : 4'h0;
    assign green = active_d[1] ? rd_data[7:4] : 4'h0;
    assign blue  = active_d[1] ? rd_data[3:0] : 4'h0;

    assign vga_hsync = hsync_d[1];
    assign vga_vsync = vsync_d[1];
    assign vga_red   = red;
    assign vga_green = green;
    assign vga_blue  = blue;

    // RGB565 with top bits repeated into the low positions
    assign screen_red         = {red, red[3]};
    assign screen_green       = {green, green[3:2]};
    assign screen_blue        = {blue, blue[3]};
    assign screen_data_enable = active_d[1];

endmodule

/* rtl/gfx_top.sv */
`timescale 1ns/1ps

module gfx_top (
    input  logic       clk_ext,
    input  logic       reset,
    // SPI
    input  logic       spi_sclk,
    input  logic       spi_ssn,
    input  logic       spi_mosi,
    output logic       spi_miso,
    // VGA
    output logic       vga_hsync,
    output logic       vga_vsync,
    output logic [3:0] vga_red,
    output logic [3:0] vga_green,
    output logic [3:0] vga_blue,
    // Screen
    output logic [4:0] screen_red,
    output logic [5:0] screen_green,
    output logic [4:0] screen_blue,
    output logic       screen_data_enable
);
    import gfx_pkg::*;

    logic       byte_valid;
    logic       byte_ready;
    logic [7:0] byte_data;
    logic       busy;
    logic       soft_reset;

    logic       draw_valid;
    logic       draw_ready;
    logic       draw_fill;
    logic [3:0] draw_x0;
    logic [2:0] draw_y0;
    logic [3:0] draw_x1;
    logic [2:0] draw_y1;
    color_t     draw_color;

    logic       wr_en;
    fb_addr_t   wr_addr;
    color_t     wr_data;
    fb_addr_t   rd_addr;
    color_t     rd_data;

    logic [$clog2(h_total)-1:0] h_pos;
    logic [$clog2(v_total)-1:0] v_pos;
    logic       active;
    logic       hsync;
    logic       vsync;

    ////////////////////
    // Command path
    ////////////////////

    spi_sub spi_sub_inst (
        .clk_ext(clk_ext),
        .reset(reset),
        .sclk(spi_sclk),
        .ssn(spi_ssn),
        .mosi(spi_mosi),
        .busy(busy),
        .soft_reset(soft_reset),
        .byte_ready(byte_ready),
        .miso(spi_miso),
        .byte_valid(byte_valid),
        .byte_data(byte_data)
    );

    cmd_decoder cmd_decoder_inst (
        .clk_ext(clk_ext),
        .reset(reset),
        .byte_valid(byte_valid),
        .byte_data(byte_data),
        .draw_ready(draw_ready),
        .byte_ready(byte_ready),
        .draw_valid(draw_valid),
        .draw_fill(draw_fill),
        .draw_x0(draw_x0),
        .draw_y0(draw_y0),
        .draw_x1(draw_x1),
        .draw_y1(draw_y1),
        .draw_color(draw_color),
        .soft_reset(soft_reset)
    );

    frame_writer frame_writer_inst (
        .clk_ext(clk_ext),
        .reset(reset),
        .draw_valid(draw_valid),
        .draw_fill(draw_fill),
        .draw_x0(draw_x0),
        .draw_y0(draw_y0),
        .draw_x1(draw_x1),
        .draw_y1(draw_y1),
        .draw_color(draw_color),
        .draw_ready(draw_ready),
        .busy(busy),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data)
    );

    frame_buffer frame_buffer_inst (
        .clk_ext(clk_ext),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

    ////////////////////
    // Display path
    ////////////////////

    video_timing video_timing_inst (
        .clk_ext(clk_ext),
        .reset(reset),
        .soft_reset(soft_reset),
        .h_pos(h_pos),
        .v_pos(v_pos),
        .active(active),
        .hsync(hsync),
        .vsync(vsync)
    );

    scanout scanout_inst (
        .clk_ext(clk_ext),
        .reset(reset),
        .h_pos(h_pos),
        .v_pos(v_pos),
        .active(active),
        .hsync(hsync),
        .vsync(vsync),
        .rd_data(rd_data),
        .rd_addr(rd_addr),
        .vga_hsync(vga_hsync),
        .vga_vsync(vga_vsync),
        .vga_red(vga_red),
        .vga_green(vga_green),
        .vga_blue(vga_blue),
        .screen_red(screen_red),
        .screen_green(screen_green),
        .screen_blue(screen_blue),
        .screen_data_enable(screen_data_enable)
    );

endmodule

/* tb/gfx_ref.svh */
`ifndef GFX_REF_SVH
`define GFX_REF_SVH

// Expected buffer contents, indexed [row][column]
logic [11:0] ref_frame [0:7][0:15];

function automatic void clear_ref();
    for (int r = 0; r < fb_height; r++) begin
        for (int c = 0; c < fb_width; c++) begin
            ref_frame[r][c] = 12'h000;
        end
    end
endfunction

// Draw one command word into the model with the first byte in the top bits
function automatic void apply_command(input logic [31:0] word);
    int x0;
    int y0;
    int x1;
    int y1;
    if (word[31:28] == 4'd1) begin
        x0 = word[24:21];
        y0 = word[27:25];
        x1 = x0;
        y1 = y0;
    end else if (word[31:28] == 4'd2) begin
        x0 = word[27:24];
        y0 = word[23:21];
        x1 = word[20:17];
        y1 = word[16:14];
    end else begin
        return;
    end
    // Empty rectangles fall through both loops
    for (int y = y0; y <= y1; y++) begin
        for (int x = x0; x <= x1; x++) begin
            ref_frame[y][x] = word[11:0];
        end
    end
endfunction

// Screen row r shows buffer row 7-r
function automatic logic [11:0] expected_vga(input int row, input int col);
    return ref_frame[fb_height - 1 - row][col];
endfunction

function automatic logic [15:0] expected_screen(input int row, input int col);
    logic [11:0] c;
    c = expected_vga(row, col);
    return {c[11:8], c[11], c[7:4], c[7:6], c[3:0], c[3]};
endfunction

// Data enable, hsync and vsync for a cycle counted from frame start
function automatic logic [2:0] expected_timing(input int cycle);
    int h;
    int v;
    int hs_start;
    int vs_start;
    logic de;
    logic hs;
    logic vs;
    h        = cycle % h_total;
    v        = (cycle / h_total) % v_total;
    hs_start = h_active + h_front;
    vs_start = v_active + v_front;
    de = (h < h_active) && (v < v_active);
    hs = (h < hs_start) || (h >= hs_start + h_sync);
    vs = (v < vs_start) || (v >= vs_start + v_sync);
    return {de, hs, vs};
endfunction

`endif

/* tb/tb_gfx_top.sv */
`timescale 1ns/1ps

module tb_gfx_top;
    import gfx_pkg::*;

    localparam int          spi_half    = 4;
    localparam int          fast_half   = 1;
    localparam logic [31:0] seed        = 32'h63fd_0aee;
    localparam int          cycle_limit = 60000;

    logic       clk_ext;
    logic       reset;
    logic       spi_sclk;
    logic       spi_ssn;
    logic       spi_mosi;
    logic       spi_miso;
    logic       vga_hsync;
    logic       vga_vsync;
    logic [3:0] vga_red;
    logic [3:0] vga_green;
    logic [3:0] vga_blue;
    logic [4:0] screen_red;
    logic [5:0] screen_green;
    logic [4:0] screen_blue;
    logic       screen_data_enable;

    logic [7:0] tx_buf [0:15];
    logic [7:0] rx_buf [0:15];
    int         errors;
    int         tests;
    int         cycle_count;
    event       capture_start;
    event       capture_done;

    `include "gfx_ref.svh"

    gfx_top gfx_top_i (
        .clk_ext(clk_ext),
        .reset(reset),
        .spi_sclk(spi_sclk),
        .spi_ssn(spi_ssn),
        .spi_mosi(spi_mosi),
        .spi_miso(spi_miso),
        .vga_hsync(vga_hsync),
        .vga_vsync(vga_vsync),
        .vga_red(vga_red),
        .vga_green(vga_green),
        .vga_blue(vga_blue),
        .screen_red(screen_red),
        .screen_green(screen_green),
        .screen_blue(screen_blue),
        .screen_data_enable(screen_data_enable)
    );

    always #50 clk_ext = ~clk_ext;

    always @(posedge clk_ext) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: run stopped after %0d cycles without finishing", cycle_count);
            $display("sim failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("ERROR %s: expected 0x%0h, got 0x%0h", name, expected, got);
            errors++;
        end
    endtask

    ////////////////////
    // SPI host
    ////////////////////

    // Mode 0, MSB first, miso sampled just before each rising sclk
    task automatic spi_frame(input int nbytes, input int half);
        @(posedge clk_ext);
        spi_ssn <= 1'b0;
        repeat (4) @(posedge clk_ext);
        for (int b = 0; b < nbytes; b++) begin
            for (int i = 7; i >= 0; i--) begin
                spi_mosi <= tx_buf[b][i];
                repeat (half - 1) @(posedge clk_ext);
                @(negedge clk_ext);
                rx_buf[b][i] = spi_miso;
                @(posedge clk_ext);
                spi_sclk <= 1'b1;
                repeat (half) @(posedge clk_ext);
                spi_sclk <= 1'b0;
            end
        end
        repeat (4) @(posedge clk_ext);
        spi_ssn <= 1'b1;
        repeat (4) @(posedge clk_ext);
    endtask

    task automatic load_word(input logic [31:0] word, input int first);
        for (int i = 0; i < 4; i++) begin
            tx_buf[first + i] = word[31 - 8 * i -: 8];
        end
    endtask

    task automatic send_command(input logic [31:0] word);
        load_word(word, 0);
        spi_frame(4, spi_half);
    endtask

    // A nop command keeps the decoder's byte count aligned
    task automatic read_status(output logic [7:0] status);
        load_word(32'h0, 0);
        spi_frame(4, spi_half);
        status = rx_buf[0];
    endtask

    task automatic wait_not_busy();
        logic [7:0] status;
        int         polls;
        polls = 1;
        read_status(status);
        while (status[0] && polls < 20) begin
            read_status(status);
            polls++;
        end
        assert (!status[0]) else begin
            $display("Writer still busy after %0d status polls", polls);
            errors++;
        end
        if (!status[0]) begin
            check_value("spi_miso status", status, 8'h00);
        end
    endtask

    function automatic logic [31:0] pixel_word(input int x, input int y, input color_t color);
        cmd_word_t w;
        w              = '0;
        w.pixel.opcode = op_pixel;
        w.pixel.x      = 4'(x);
        w.pixel.y      = 3'(y);
        w.pixel.color  = color;
        return w;
    endfunction

    function automatic logic [31:0] fill_word(input int x0, input int y0, input int x1,
                                              input int y1, input color_t color);
        cmd_word_t w;
        w             = '0;
        w.fill.opcode = op_fill;
        w.fill.x0     = 4'(x0);
        w.fill.y0     = 3'(y0);
        w.fill.x1     = 4'(x1);
        w.fill.y1     = 3'(y1);
        w.fill.color  = color;
        return w;
    endfunction

    ////////////////////
    // Frame checks
    ////////////////////

    // Row and column come from the count of enabled cycles after vsync
    always begin : compare_frames
        int          pixels;
        int          row;
        int          col;
        string       where;
        logic [11:0] exp_color;
        @(capture_start);
        do @(negedge clk_ext); while (vga_vsync !== 1'b0);
        do @(negedge clk_ext); while (vga_vsync !== 1'b1);
        pixels = 0;
        while (pixels < fb_width * fb_height) begin
            @(negedge clk_ext);
            if (screen_data_enable === 1'b1) begin
                row       = pixels / fb_width;
                col       = pixels % fb_width;
                where     = $sformatf(" at row %0d col %0d", row, col);
                exp_color = expected_vga(row, col);
                check_value({"vga_red", where}, vga_red, exp_color[11:8]);
                check_value({"vga_green", where}, vga_green, exp_color[7:4]);
                check_value({"vga_blue", where}, vga_blue, exp_color[3:0]);
                check_value({"screen_rgb565", where}, {screen_red, screen_green, screen_blue},
                            expected_screen(row, col));
                pixels++;
            end else begin
                // Blanking must hide whatever the buffer holds
                check_value("vga_rgb in blanking", {vga_red, vga_green, vga_blue}, 12'h000);
                check_value("screen_rgb565 in blanking",
                            {screen_red, screen_green, screen_blue}, 16'h0000);
            end
        end
        -> capture_done;
    end

    task automatic capture_frame();
        -> capture_start;
        @(capture_done);
    endtask

    // Starts at the first enabled cycle after reset, which is row 0 column 0
    task automatic check_timing(input int frames);
        logic [2:0] expected;
        int         active_count;
        active_count = 0;
        do @(negedge clk_ext); while (screen_data_enable !== 1'b1);
        for (int k = 0; k < frames * h_total * v_total; k++) begin
            expected = expected_timing(k);
            check_value("screen_data_enable", screen_data_enable, expected[2]);
            check_value("vga_hsync", vga_hsync, expected[1]);
            check_value("vga_vsync", vga_vsync, expected[0]);
            check_value("vga_rgb", {vga_red, vga_green, vga_blue}, 12'h000);
            check_value("screen_rgb565", {screen_red, screen_green, screen_blue}, 16'h0000);
            if (screen_data_enable === 1'b1) begin
                active_count++;
            end
            @(negedge clk_ext);
        end
        check_value("active cycle count", active_count, frames * fb_width * fb_height);
    endtask

    task automatic report_test(input string name, input int mark);
        tests++;
        if (errors == mark) begin
            $display("Test %0d %s: ok", tests, name);
        end else begin
            $display("Test %0d %s: %0d errors", tests, name, errors - mark);
        end
    endtask

    ////////////////////
    // Sequence
    ////////////////////

    initial begin : main_sequence
        logic [31:0] word;
        logic [31:0] held;
        int          mark;
        clk_ext     = 1'b0;
        reset       = 1'b1;
        spi_sclk    = 1'b0;
        spi_ssn     = 1'b1;
        spi_mosi    = 1'b0;
        errors      = 0;
        tests       = 0;
        cycle_count = 0;
        void'($urandom(seed));
        clear_ref();

        mark = errors;
        repeat (2) @(posedge clk_ext);
        @(negedge clk_ext);
        check_value("screen_data_enable", screen_data_enable, 1'b0);
        check_value("vga_hsync", vga_hsync, 1'b1);
        check_value("vga_vsync", vga_vsync, 1'b1);
        @(posedge clk_ext);
        reset <= 1'b0;
        check_timing(2);
        report_test("timing after reset", mark);

        mark = errors;
        for (int n = 0; n < 10; n++) begin
            word = pixel_word($urandom_range(15, 0), $urandom_range(7, 0), 12'($urandom));
            send_command(word);
            apply_command(word);
            wait_not_busy();
        end
        capture_frame();
        report_test("random pixel writes", mark);

        mark = errors;
        for (int n = 0; n < 7; n++) begin
            if (n == 4) begin
                word = fill_word(9, 1, 3, 6, 12'($urandom));
            end else if (n == 5) begin
                word = fill_word(2, 5, 12, 2, 12'($urandom));
            end else if (n == 6) begin
                word = fill_word(11, 4, 15, 7, 12'($urandom));
            end else begin
                word = fill_word($urandom_range(15, 0), $urandom_range(7, 0),
                                 $urandom_range(15, 0), $urandom_range(7, 0), 12'($urandom));
            end
            send_command(word);
            apply_command(word);
            wait_not_busy();
        end
        capture_frame();
        report_test("fill rectangles", mark);

        // Fast burst where the pixel waits behind the fill and the last pad byte overruns
        mark = errors;
        word = fill_word(0, 0, 15, 7, 12'($urandom));
        held = pixel_word($urandom_range(15, 0), $urandom_range(7, 0), 12'($urandom));
        load_word(word, 0);
        load_word(held, 4);
        tx_buf[8] = 8'h00;
        tx_buf[9] = 8'h00;
        spi_frame(10, fast_half);
        apply_command(word);
        apply_command(held);
        // Three zero bytes complete a nop with the pad byte the decoder kept
        load_word(32'h0, 0);
        spi_frame(3, spi_half);
        check_value("spi_miso status byte 0", rx_buf[0], 8'h03);
        check_value("spi_miso status byte 1", rx_buf[1], 8'h02);
        capture_frame();
        report_test("busy and overrun", mark);

        mark = errors;
        word = '0;
        word[31:28] = 4'd3;
        send_command(word);
        check_value("spi_miso status before soft reset", rx_buf[0], 8'h02);
        wait_not_busy();
        capture_frame();
        word = pixel_word($urandom_range(15, 0), $urandom_range(7, 0), 12'($urandom));
        send_command(word);
        apply_command(word);
        wait_not_busy();
        capture_frame();
        report_test("soft reset", mark);

        $display("Tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* gfx_top.f */
+incdir+tb
rtl/gfx_pkg.sv
rtl/spi_sub.sv
rtl/cmd_decoder.sv
rtl/frame_writer.sv
rtl/frame_buffer.sv
rtl/video_timing.sv
rtl/scanout.sv
rtl/gfx_top.sv
tb/tb_gfx_top.sv
